//--- dv/mem_subsys_tb.sv
// Testbench for the memory subsystem top level.
// Reads only target words that were written first, since the SRAM
// contents are not reset. Responses are checked against a word model
// by concurrent assertions; the first error ends the run.

`timescale 1ns/1ps

module mem_subsys_tb;

	localparam logic [31:0] SLAVE_BASE    = 32'h1000_0000;
	localparam logic [31:0] SLAVE_LIMIT   = 32'h1000_FFFF;
	localparam int          MEM_ADDR_BITS = 10;
	localparam int          WAIT_STATES   = 2;
	localparam int          MEM_WORDS     = 2**MEM_ADDR_BITS;
	localparam int          MEM_BYTES     = 4 * MEM_WORDS;

	// 200 commands, at most about 25 cycles each with stalls.
	localparam int N_CMDS         = 200;
	localparam int TIMEOUT_CYCLES = N_CMDS * 25;

	logic                clk = 1'b0;
	logic                i_rst;
	logic                i_cmd_valid;
	logic                i_cmd_write;
	logic [31:0]         i_cmd_addr;
	logic [31:0]         i_cmd_wdata;
	logic [3:0]          i_cmd_strb;
	logic                o_cmd_ready;
	logic                i_rsp_ready;
	logic                o_rsp_valid;
	logic [31:0]         o_rsp_rdata;
	mem_bus_pkg::resp_t  o_rsp_resp;

	integer              seed = 32'h913b;
	integer              stall_seed;
	logic [31:0]         model [MEM_WORDS];
	logic [31:0]         known [$];
	logic [31:0]         exp_rdata;
	mem_bus_pkg::resp_t  exp_resp;
	logic                pending;
	int                  lat;
	int                  cmd_count = 0;
	int                  rsp_count;
	int                  cycles = 0;
	int                  stall_left;
	logic [31:0]         rnd_stall;

	mem_subsys_top #(
		.SLAVE_BASE    (SLAVE_BASE),
		.SLAVE_LIMIT   (SLAVE_LIMIT),
		.MEM_ADDR_BITS (MEM_ADDR_BITS),
		.WAIT_STATES   (WAIT_STATES)
	) DUT (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_cmd_valid (i_cmd_valid),
		.i_cmd_write (i_cmd_write),
		.i_cmd_addr  (i_cmd_addr),
		.i_cmd_wdata (i_cmd_wdata),
		.i_cmd_strb  (i_cmd_strb),
		.o_cmd_ready (o_cmd_ready),
		.i_rsp_ready (i_rsp_ready),
		.o_rsp_valid (o_rsp_valid),
		.o_rsp_rdata (o_rsp_rdata),
		.o_rsp_resp  (o_rsp_resp)
	);

	always #20 clk = ~clk;

	// ============================================================
	// failure reporting
	// ============================================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string what);
		abort_run($sformatf("CHECK FAILED at %0t: %s", $time, what));
	endtask

	// ============================================================
	// reference model
	// ============================================================

	// expected response from the window and memory size rules.
	function automatic void predict_response(input logic write, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [3:0] strb);
		logic [31:0] off;
		logic [31:0] word;
		off = addr - SLAVE_BASE;
		exp_rdata = '0;
		if (addr < SLAVE_BASE || addr > SLAVE_LIMIT) begin
			exp_resp = mem_bus_pkg::RESP_DECERR;
		end else if (off >= MEM_BYTES) begin
			exp_resp = mem_bus_pkg::RESP_SLVERR;
		end else begin
			exp_resp = mem_bus_pkg::RESP_OKAY;
			word = model[off[MEM_ADDR_BITS+1:2]];
			if (write) begin
				for (int b = 0; b < 4; b++) begin
					if (strb[b]) begin
						word[8*b +: 8] = wdata[8*b +: 8];
					end
				end
				model[off[MEM_ADDR_BITS+1:2]] = word;
			end else begin
				exp_rdata = word;
			end
		end
	endfunction

	function automatic logic [31:0] pick_known_addr();
		int unsigned idx;
		idx = {$random(seed)} % known.size();
		return known[idx];
	endfunction

	// called on a falling edge; returns on the falling edge after acceptance.
	task automatic issue_command(input logic write, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [3:0] strb);
		i_cmd_valid = 1'b1;
		i_cmd_write = write;
		i_cmd_addr  = addr;
		i_cmd_wdata = wdata;
		i_cmd_strb  = strb;
		while (!o_cmd_ready) begin
			@(negedge clk);
		end
		predict_response(write, addr, wdata, strb);
		cmd_count++;
		@(negedge clk);
		i_cmd_valid = 1'b0;
	endtask

	// ============================================================
	// response bookkeeping and checks
	// ============================================================

	always @(posedge clk) begin
		if (i_rst) begin
			pending   <= 1'b0;
			lat       <= 0;
			rsp_count <= 0;
		end else begin
			if (i_cmd_valid && o_cmd_ready) begin
				pending <= 1'b1;
				lat     <= 0;
			end else if (o_rsp_valid && i_rsp_ready) begin
				pending <= 1'b0;
			end else if (pending && !o_rsp_valid) begin
				lat <= lat + 1;
			end
			if (o_rsp_valid && i_rsp_ready) begin
				rsp_count <= rsp_count + 1;
			end
		end
	end

	assert property (@(posedge clk) $fell(i_rst) |-> o_cmd_ready && !o_rsp_valid)
		else report_mismatch("bad handshake state right after reset");

	assert property (@(posedge clk) disable iff (i_rst)
		o_rsp_valid |-> (o_rsp_resp == exp_resp) && (o_rsp_rdata == exp_rdata))
		else report_mismatch("response differs from the reference model");

	assert property (@(posedge clk) disable iff (i_rst)
		o_rsp_valid && !i_rsp_ready |=>
			o_rsp_valid && $stable(o_rsp_rdata) && $stable(o_rsp_resp))
		else report_mismatch("response dropped or changed under back-pressure");

	assert property (@(posedge clk) disable iff (i_rst) pending |-> !o_cmd_ready)
		else report_mismatch("command ready while a command is in flight");

	assert property (@(posedge clk) disable iff (i_rst) o_rsp_valid |-> pending)
		else report_mismatch("response without an accepted command");

	// response due by cycle WAIT_STATES+3 after acceptance.
	assert property (@(posedge clk) disable iff (i_rst)
		pending && !o_rsp_valid |-> lat < WAIT_STATES + 2)
		else report_mismatch("response later than the latency bound");

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("timeout: run did not finish within %0d cycles",
				TIMEOUT_CYCLES));
		end
	end

	// random response stalls of up to seven cycles.
	initial begin
		i_rsp_ready = 1'b0;
		stall_left  = 0;
		stall_seed  = seed ^ 32'h0000_7e11;
		forever begin
			@(negedge clk);
			if (stall_left > 0) begin
				i_rsp_ready = 1'b0;
				stall_left  = stall_left - 1;
			end else begin
				rnd_stall = $random(stall_seed);
				if (rnd_stall[1:0] == 2'b00) begin
					i_rsp_ready = 1'b0;
					stall_left  = int'(rnd_stall[4:2]);
				end else begin
					i_rsp_ready = 1'b1;
				end
			end
		end
	end

	// ============================================================
	// stimulus
	// ============================================================

	initial begin
		logic [31:0] addr;
		logic [31:0] known_addr;
		logic [31:0] data;
		logic [31:0] rnd;
		i_rst       = 1'b1;
		i_cmd_valid = 1'b0;
		i_cmd_write = 1'b0;
		i_cmd_addr  = '0;
		i_cmd_wdata = '0;
		i_cmd_strb  = '0;
		exp_rdata   = '0;
		exp_resp    = mem_bus_pkg::RESP_OKAY;
		repeat (8) @(negedge clk);
		i_rst = 1'b0;
		@(negedge clk);

		// full-word writes, then read-back.
		for (int i = 0; i < 40; i++) begin
			addr = SLAVE_BASE + ($random(seed) & 32'h0000_0ffc);
			data = $random(seed);
			issue_command(1'b1, addr, data, 4'hf);
			known.push_back(addr);
		end
		for (int i = 0; i < 40; i++) begin
			issue_command(1'b0, pick_known_addr(), '0, 4'h0);
		end

		// partial strobes, each followed by a read.
		for (int i = 0; i < 30; i++) begin
			addr = pick_known_addr();
			data = $random(seed);
			rnd  = $random(seed);
			issue_command(1'b1, addr, data, rnd[3:0]);
			issue_command(1'b0, addr, '0, 4'h0);
		end

		// outside the window, below and above, on the low bits of a written word.
		for (int i = 0; i < 10; i++) begin
			known_addr = pick_known_addr();
			rnd        = $random(seed);
			if (i % 2 == 0) begin
				addr = (known_addr - SLAVE_BASE) | (rnd & 32'h0fff_f000);
			end else begin
				addr = known_addr + 32'h0001_0000 + (rnd & 32'h0fff_0000);
			end
			issue_command(1'b1, addr, $random(seed), 4'hf);
			issue_command(1'b0, addr, '0, 4'h0);
			issue_command(1'b0, known_addr, '0, 4'h0);
		end

		// inside the window but past the SRAM, aliasing a written word.
		for (int i = 0; i < 10; i++) begin
			known_addr = pick_known_addr();
			addr = known_addr + MEM_BYTES * (1 + {$random(seed)} % 15);
			issue_command(1'b1, addr, $random(seed), 4'hf);
			issue_command(1'b0, addr, '0, 4'h0);
			issue_command(1'b0, known_addr, '0, 4'h0);
		end

		while (pending || o_rsp_valid) begin
			@(negedge clk);
		end
		@(negedge clk);
		if (rsp_count == cmd_count) begin
			$display("All tests passed!");
			$finish;
		end else begin
			report_mismatch($sformatf("%0d responses for %0d commands",
				rsp_count, cmd_count));
		end
	end

endmodule

//--- mem_subsys.f
src/mem_bus_pkg.sv
src/wait_state_timer.sv
src/bus_master_fsm.sv
src/addr_window_xbar.sv
src/sram_slave.sv
src/mem_subsys_top.sv
dv/mem_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f mem_subsys.f --top-module mem_subsys_tb -o mem_subsys_sim \
	&& ./obj_dir/mem_subsys_sim \
	|| { echo "mem_subsys simulation failed"; exit 1; }

//--- src/addr_window_xbar.sv
// One master to one slave interconnect with an address window.
// In-window traffic passes through with no added cycles and the
// address rebased to an offset from SLAVE_BASE.
// Out-of-window requests get RESP_DECERR one cycle after acceptance.
// Assumes one transaction in flight from the master.

`timescale 1ns/1ps

module addr_window_xbar #(
	parameter logic [mem_bus_pkg::ADDR_W-1:0] SLAVE_BASE  = 32'h1000_0000,
	parameter logic [mem_bus_pkg::ADDR_W-1:0] SLAVE_LIMIT = 32'h1000_FFFF
) (
	input  logic                              clk,
	input  logic                              i_rst,

	// from the master.
	input  logic                              i_m_wr_valid,
	input  logic [mem_bus_pkg::ADDR_W-1:0]    i_m_wr_addr,
	input  logic [mem_bus_pkg::DATA_W-1:0]    i_m_wr_data,
	input  logic [mem_bus_pkg::STRB_W-1:0]    i_m_wr_strb,
	output logic                              o_m_wr_ready,
	output logic                              o_m_b_valid,
	output mem_bus_pkg::resp_t                o_m_b_resp,
	input  logic                              i_m_b_ready,
	input  logic                              i_m_ar_valid,
	input  logic [mem_bus_pkg::ADDR_W-1:0]    i_m_ar_addr,
	output logic                              o_m_ar_ready,
	output logic                              o_m_r_valid,
	output logic [mem_bus_pkg::DATA_W-1:0]    o_m_r_data,
	output mem_bus_pkg::resp_t                o_m_r_resp,
	input  logic                              i_m_r_ready,

	// toward the slave.
	output logic                              o_s_wr_valid,
	output logic [mem_bus_pkg::ADDR_W-1:0]    o_s_wr_addr,
	output logic [mem_bus_pkg::DATA_W-1:0]    o_s_wr_data,
	output logic [mem_bus_pkg::STRB_W-1:0]    o_s_wr_strb,
	input  logic                              i_s_wr_ready,
	input  logic                              i_s_b_valid,
	input  mem_bus_pkg::resp_t                i_s_b_resp,
	output logic                              o_s_b_ready,
	output logic                              o_s_ar_valid,
	output logic [mem_bus_pkg::ADDR_W-1:0]    o_s_ar_addr,
	input  logic                              i_s_ar_ready,
	input  logic                              i_s_r_valid,
	input  logic [mem_bus_pkg::DATA_W-1:0]    i_s_r_data,
	input  mem_bus_pkg::resp_t                i_s_r_resp,
	output logic                              o_s_r_ready
);

	logic wr_hit;
	logic ar_hit;
	logic err_b_valid;
	logic err_r_valid;

	// ============================================================
	// window decode and request routing
	// ============================================================

	assign wr_hit = (i_m_wr_addr >= SLAVE_BASE) && (i_m_wr_addr <= SLAVE_LIMIT);
	assign ar_hit = (i_m_ar_addr >= SLAVE_BASE) && (i_m_ar_addr <= SLAVE_LIMIT);

	assign o_s_wr_valid = i_m_wr_valid && wr_hit;
	assign o_s_wr_addr  = i_m_wr_addr - SLAVE_BASE;
	assign o_s_wr_data  = i_m_wr_data;
	assign o_s_wr_strb  = i_m_wr_strb;

	assign o_s_ar_valid = i_m_ar_valid && ar_hit;
	assign o_s_ar_addr  = i_m_ar_addr - SLAVE_BASE;

	// misses are absorbed here while the error responder is free.
	assign o_m_wr_ready = wr_hit ? i_s_wr_ready : !err_b_valid;
	assign o_m_ar_ready = ar_hit ? i_s_ar_ready : !err_r_valid;

	// ============================================================
	// decode-error responder
	// ============================================================

	always_ff @(posedge clk) begin
		if (i_rst) begin
			err_b_valid <= 1'b0;
			err_r_valid <= 1'b0;
		end else begin
			if (i_m_wr_valid && !wr_hit && !err_b_valid) begin
				err_b_valid <= 1'b1;
			end else if (err_b_valid && i_m_b_ready) begin
				err_b_valid <= 1'b0;
			end
			if (i_m_ar_valid && !ar_hit && !err_r_valid) begin
				err_r_valid <= 1'b1;
			end else if (err_r_valid && i_m_r_ready) begin
				err_r_valid <= 1'b0;
			end
		end
	end

	// response merge.
	assign o_m_b_valid = i_s_b_valid || err_b_valid;
	assign o_m_b_resp  = err_b_valid ? mem_bus_pkg::RESP_DECERR : i_s_b_resp;
	assign o_s_b_ready = i_m_b_ready && !err_b_valid;

	assign o_m_r_valid = i_s_r_valid || err_r_valid;
	assign o_m_r_data  = err_r_valid ? '0 : i_s_r_data;
	assign o_m_r_resp  = err_r_valid ? mem_bus_pkg::RESP_DECERR : i_s_r_resp;
	assign o_s_r_ready = i_m_r_ready && !err_r_valid;

endmodule

//--- src/bus_master_fsm.sv
// Bus master for single loads and stores.
// One transaction in flight; a new command waits for the response
// to be taken at the response port.
// Read data is forced to zero for writes and for errored reads.

`timescale 1ns/1ps

module bus_master_fsm (
	input  logic                              clk,
	input  logic                              i_rst,

	// command and response port.
	input  logic                              i_cmd_valid,
	input  logic                              i_cmd_write,
	input  logic [mem_bus_pkg::ADDR_W-1:0]    i_cmd_addr,
	input  logic [mem_bus_pkg::DATA_W-1:0]    i_cmd_wdata,
	input  logic [mem_bus_pkg::STRB_W-1:0]    i_cmd_strb,
	output logic                              o_cmd_ready,
	output logic                              o_rsp_valid,
	output logic [mem_bus_pkg::DATA_W-1:0]    o_rsp_rdata,
	output mem_bus_pkg::resp_t                o_rsp_resp,
	input  logic                              i_rsp_ready,

	// bus master side.
	output logic                              o_wr_valid,
	output logic [mem_bus_pkg::ADDR_W-1:0]    o_wr_addr,
	output logic [mem_bus_pkg::DATA_W-1:0]    o_wr_data,
	output logic [mem_bus_pkg::STRB_W-1:0]    o_wr_strb,
	input  logic                              i_wr_ready,
	input  logic                              i_b_valid,
	input  mem_bus_pkg::resp_t                i_b_resp,
	output logic                              o_b_ready,
	output logic                              o_ar_valid,
	output logic [mem_bus_pkg::ADDR_W-1:0]    o_ar_addr,
	input  logic                              i_ar_ready,
	input  logic                              i_r_valid,
	input  logic [mem_bus_pkg::DATA_W-1:0]    i_r_data,
	input  mem_bus_pkg::resp_t                i_r_resp,
	output logic                              o_r_ready
);

	typedef enum logic [2:0] {
		IDLE,
		WRITE_REQ,
		WRITE_RESP,
		READ_REQ,
		READ_RESP,
		RESPOND
	} state_t;

	state_t state;

	logic [mem_bus_pkg::ADDR_W-1:0] addr_q;
	logic [mem_bus_pkg::DATA_W-1:0] wdata_q;
	logic [mem_bus_pkg::STRB_W-1:0] strb_q;
	logic [mem_bus_pkg::DATA_W-1:0] rdata_q;
	mem_bus_pkg::resp_t             resp_q;

	// ============================================================
	// state sequencing
	// ============================================================

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (i_cmd_valid) begin
						state <= i_cmd_write ? WRITE_REQ : READ_REQ;
					end
				end
				WRITE_REQ:  if (i_wr_ready) state <= WRITE_RESP;
				WRITE_RESP: if (i_b_valid)  state <= RESPOND;
				READ_REQ:   if (i_ar_ready) state <= READ_RESP;
				READ_RESP:  if (i_r_valid)  state <= RESPOND;
				RESPOND:    if (i_rsp_ready) state <= IDLE;
				default:    state <= IDLE;
			endcase
		end
	end

	// ============================================================
	// command and response capture
	// ============================================================

	always_ff @(posedge clk) begin
		if (state == IDLE && i_cmd_valid) begin
			addr_q  <= i_cmd_addr;
			wdata_q <= i_cmd_wdata;
			strb_q  <= i_cmd_strb;
		end
		if (state == WRITE_RESP && i_b_valid) begin
			rdata_q <= '0;
			resp_q  <= i_b_resp;
		end
		if (state == READ_RESP && i_r_valid) begin
			rdata_q <= (i_r_resp == mem_bus_pkg::RESP_OKAY) ? i_r_data : '0;
			resp_q  <= i_r_resp;
		end
	end

	assign o_cmd_ready = (state == IDLE);

	assign o_wr_valid = (state == WRITE_REQ);
	assign o_wr_addr  = addr_q;
	assign o_wr_data  = wdata_q;
	assign o_wr_strb  = strb_q;
	assign o_b_ready  = (state == WRITE_RESP);

	assign o_ar_valid = (state == READ_REQ);
	assign o_ar_addr  = addr_q;
	assign o_r_ready  = (state == READ_RESP);

	assign o_rsp_valid = (state == RESPOND);
	assign o_rsp_rdata = rdata_q;
	assign o_rsp_resp  = resp_q;

endmodule

//--- src/mem_bus_pkg.sv
// Shared bus definitions for the memory subsystem.
// Data width must be a whole number of bytes.
// Response encodings follow the AXI-lite convention.

package mem_bus_pkg;

	// ============================================================
	// bus widths
	// ============================================================

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// one strobe bit per data byte.
	localparam int STRB_W = DATA_W / 8;

	// ============================================================
	// response codes
	// ============================================================

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_t;

endpackage

//--- src/mem_subsys_top.sv
// Memory subsystem top level: bus master, address window, SRAM.
// The window is wider than the SRAM, so in-window offsets past the
// memory end return a slave error and other addresses a decode error.

`timescale 1ns/1ps

module mem_subsys_top #(
	parameter logic [mem_bus_pkg::ADDR_W-1:0] SLAVE_BASE  = 32'h1000_0000,
	parameter logic [mem_bus_pkg::ADDR_W-1:0] SLAVE_LIMIT = 32'h1000_FFFF,
	parameter int                             MEM_ADDR_BITS = 10,
	parameter int                             WAIT_STATES   = 2
) (
	input  logic                              clk,
	input  logic                              i_rst,
	input  logic                              i_cmd_valid,
	input  logic                              i_cmd_write,
	input  logic [mem_bus_pkg::ADDR_W-1:0]    i_cmd_addr,
	input  logic [mem_bus_pkg::DATA_W-1:0]    i_cmd_wdata,
	input  logic [mem_bus_pkg::STRB_W-1:0]    i_cmd_strb,
	output logic                              o_cmd_ready,
	input  logic                              i_rsp_ready,
	output logic                              o_rsp_valid,
	output logic [mem_bus_pkg::DATA_W-1:0]    o_rsp_rdata,
	output mem_bus_pkg::resp_t                o_rsp_resp
);

	// ============================================================
	// master to interconnect
	// ============================================================

	logic                           m_wr_valid;
	logic [mem_bus_pkg::ADDR_W-1:0] m_wr_addr;
	logic [mem_bus_pkg::DATA_W-1:0] m_wr_data;
	logic [mem_bus_pkg::STRB_W-1:0] m_wr_strb;
	logic                           m_wr_ready;
	logic                           m_b_valid;
	mem_bus_pkg::resp_t             m_b_resp;
	logic                           m_b_ready;
	logic                           m_ar_valid;
	logic [mem_bus_pkg::ADDR_W-1:0] m_ar_addr;
	logic                           m_ar_ready;
	logic                           m_r_valid;
	logic [mem_bus_pkg::DATA_W-1:0] m_r_data;
	mem_bus_pkg::resp_t             m_r_resp;
	logic                           m_r_ready;

	// ============================================================
	// interconnect to slave
	// ============================================================

	logic                           s_wr_valid;
	logic [mem_bus_pkg::ADDR_W-1:0] s_wr_addr;
	logic [mem_bus_pkg::DATA_W-1:0] s_wr_data;
	logic [mem_bus_pkg::STRB_W-1:0] s_wr_strb;
	logic                           s_wr_ready;
	logic                           s_b_valid;
	mem_bus_pkg::resp_t             s_b_resp;
	logic                           s_b_ready;
	logic                           s_ar_valid;
	logic [mem_bus_pkg::ADDR_W-1:0] s_ar_addr;
	logic                           s_ar_ready;
	logic                           s_r_valid;
	logic [mem_bus_pkg::DATA_W-1:0] s_r_data;
	mem_bus_pkg::resp_t             s_r_resp;
	logic                           s_r_ready;

	bus_master_fsm u_master (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_cmd_valid (i_cmd_valid),
		.i_cmd_write (i_cmd_write),
		.i_cmd_addr  (i_cmd_addr),
		.i_cmd_wdata (i_cmd_wdata),
		.i_cmd_strb  (i_cmd_strb),
		.o_cmd_ready (o_cmd_ready),
		.o_rsp_valid (o_rsp_valid),
		.o_rsp_rdata (o_rsp_rdata),
		.o_rsp_resp  (o_rsp_resp),
		.i_rsp_ready (i_rsp_ready),
		.o_wr_valid  (m_wr_valid),
		.o_wr_addr   (m_wr_addr),
		.o_wr_data   (m_wr_data),
		.o_wr_strb   (m_wr_strb),
		.i_wr_ready  (m_wr_ready),
		.i_b_valid   (m_b_valid),
		.i_b_resp    (m_b_resp),
		.o_b_ready   (m_b_ready),
		.o_ar_valid  (m_ar_valid),
		.o_ar_addr   (m_ar_addr),
		.i_ar_ready  (m_ar_ready),
		.i_r_valid   (m_r_valid),
		.i_r_data    (m_r_data),
		.i_r_resp    (m_r_resp),
		.o_r_ready   (m_r_ready)
	);

	addr_window_xbar #(
		.SLAVE_BASE  (SLAVE_BASE),
		.SLAVE_LIMIT (SLAVE_LIMIT)
	) u_xbar (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_m_wr_valid (m_wr_valid),
		.i_m_wr_addr  (m_wr_addr),
		.i_m_wr_data  (m_wr_data),
		.i_m_wr_strb  (m_wr_strb),
		.o_m_wr_ready (m_wr_ready),
		.o_m_b_valid  (m_b_valid),
		.o_m_b_resp   (m_b_resp),
		.i_m_b_ready  (m_b_ready),
		.i_m_ar_valid (m_ar_valid),
		.i_m_ar_addr  (m_ar_addr),
		.o_m_ar_ready (m_ar_ready),
		.o_m_r_valid  (m_r_valid),
		.o_m_r_data   (m_r_data),
		.o_m_r_resp   (m_r_resp),
		.i_m_r_ready  (m_r_ready),
		.o_s_wr_valid (s_wr_valid),
		.o_s_wr_addr  (s_wr_addr),
		.o_s_wr_data  (s_wr_data),
		.o_s_wr_strb  (s_wr_strb),
		.i_s_wr_ready (s_wr_ready),
		.i_s_b_valid  (s_b_valid),
		.i_s_b_resp   (s_b_resp),
		.o_s_b_ready  (s_b_ready),
		.o_s_ar_valid (s_ar_valid),
		.o_s_ar_addr  (s_ar_addr),
		.i_s_ar_ready (s_ar_ready),
		.i_s_r_valid  (s_r_valid),
		.i_s_r_data   (s_r_data),
		.i_s_r_resp   (s_r_resp),
		.o_s_r_ready  (s_r_ready)
	);

	sram_slave #(
		.MEM_ADDR_BITS (MEM_ADDR_BITS),
		.WAIT_STATES   (WAIT_STATES)
	) u_sram (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_wr_valid (s_wr_valid),
		.i_wr_addr  (s_wr_addr),
		.i_wr_data  (s_wr_data),
		.i_wr_strb  (s_wr_strb),
		.o_wr_ready (s_wr_ready),
		.o_b_valid  (s_b_valid),
		.o_b_resp   (s_b_resp),
		.i_b_ready  (s_b_ready),
		.i_ar_valid (s_ar_valid),
		.i_ar_addr  (s_ar_addr),
		.o_ar_ready (s_ar_ready),
		.o_r_valid  (s_r_valid),
		.o_r_data   (s_r_data),
		.o_r_resp   (s_r_resp),
		.i_r_ready  (s_r_ready)
	);

endmodule

//--- src/sram_slave.sv
// Word-addressed SRAM bus slave with byte strobes.
// Addresses are byte offsets; the low two bits are ignored.
// Offsets at or beyond the memory size answer RESP_SLVERR and
// leave the memory unchanged. Memory contents are not reset.
// A write request wins if both requests arrive together.

`timescale 1ns/1ps

module sram_slave #(
	parameter int MEM_ADDR_BITS = 10,
	parameter int WAIT_STATES   = 2
) (
	input  logic                              clk,
	input  logic                              i_rst,
	input  logic                              i_wr_valid,
	input  logic [mem_bus_pkg::ADDR_W-1:0]    i_wr_addr,
	input  logic [mem_bus_pkg::DATA_W-1:0]    i_wr_data,
	input  logic [mem_bus_pkg::STRB_W-1:0]    i_wr_strb,
	output logic                              o_wr_ready,
	output logic                              o_b_valid,
	output mem_bus_pkg::resp_t                o_b_resp,
	input  logic                              i_b_ready,
	input  logic                              i_ar_valid,
	input  logic [mem_bus_pkg::ADDR_W-1:0]    i_ar_addr,
	output logic                              o_ar_ready,
	output logic                              o_r_valid,
	output logic [mem_bus_pkg::DATA_W-1:0]    o_r_data,
	output mem_bus_pkg::resp_t                o_r_resp,
	input  logic                              i_r_ready
);

	localparam int TOP = MEM_ADDR_BITS + 2;

	logic [mem_bus_pkg::DATA_W-1:0] mem [2**MEM_ADDR_BITS];

	logic busy;
	logic is_wr;
	logic wr_fire;
	logic ar_fire;
	logic wr_in_range;
	logic ar_in_range;
	logic done;
	logic [mem_bus_pkg::DATA_W-1:0] rdata_q;
	mem_bus_pkg::resp_t             resp_q;

	assign o_wr_ready = !busy;
	assign o_ar_ready = !busy && !i_wr_valid;
	assign wr_fire    = i_wr_valid && o_wr_ready;
	assign ar_fire    = i_ar_valid && o_ar_ready;

	// upper offset bits must be clear.
	assign wr_in_range = (i_wr_addr[mem_bus_pkg::ADDR_W-1:TOP] == '0);
	assign ar_in_range = (i_ar_addr[mem_bus_pkg::ADDR_W-1:TOP] == '0);

	wait_state_timer #(
		.LOAD_VALUE (WAIT_STATES)
	) u_timer (
		.clk    (clk),
		.i_rst  (i_rst),
		.i_load (wr_fire || ar_fire),
		.o_done (done)
	);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			busy <= 1'b0;
		end else if (wr_fire || ar_fire) begin
			busy <= 1'b1;
		end else if ((o_b_valid && i_b_ready) || (o_r_valid && i_r_ready)) begin
			busy <= 1'b0;
		end
	end

	// ============================================================
	// memory access and response capture
	// ============================================================

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			is_wr   <= 1'b1;
			rdata_q <= '0;
			resp_q  <= wr_in_range ? mem_bus_pkg::RESP_OKAY : mem_bus_pkg::RESP_SLVERR;
			if (wr_in_range) begin
				for (int b = 0; b < mem_bus_pkg::STRB_W; b++) begin
					if (i_wr_strb[b]) begin
						mem[i_wr_addr[TOP-1:2]][8*b +: 8] <= i_wr_data[8*b +: 8];
					end
				end
			end
		end else if (ar_fire) begin
			is_wr   <= 1'b0;
			rdata_q <= ar_in_range ? mem[i_ar_addr[TOP-1:2]] : '0;
			resp_q  <= ar_in_range ? mem_bus_pkg::RESP_OKAY : mem_bus_pkg::RESP_SLVERR;
		end
	end

	assign o_b_valid = busy && is_wr && done;
	assign o_b_resp  = resp_q;
	assign o_r_valid = busy && !is_wr && done;
	assign o_r_data  = rdata_q;
	assign o_r_resp  = resp_q;

endmodule

//--- src/wait_state_timer.sv
// Loadable down-counter for slave wait states.
// o_done stays high until the next load.
// With LOAD_VALUE of zero, o_done is high in the load cycle itself.

`timescale 1ns/1ps

module wait_state_timer #(
	parameter int LOAD_VALUE = 2
) (
	input  logic clk,
	input  logic i_rst,
	input  logic i_load,
	output logic o_done
);

	localparam int CNT_W = (LOAD_VALUE > 0) ? $clog2(LOAD_VALUE + 1) : 1;

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			count <= '0;
		end else if (i_load) begin
			count <= CNT_W'(LOAD_VALUE);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// a fresh load hides the stale zero, unless no wait is wanted.
	assign o_done = (count == '0) && (!i_load || (LOAD_VALUE == 0));

endmodule
